// ==== rp_frontend_top.f ====
hw/rp_frontend_pkg.sv
hw/rp_reset_seq.sv
hw/rp_adc_fmt.sv
hw/rp_pdm.sv
hw/rp_exp_pins.sv
hw/rp_frontend_top.sv
test/tb_rp_frontend.sv

// ==== Bender.yml ====
package:
  name: rp_frontend

sources:
  - files:
      - hw/rp_frontend_pkg.sv
      - hw/rp_reset_seq.sv
      - hw/rp_adc_fmt.sv
      - hw/rp_pdm.sv
      - hw/rp_exp_pins.sv
      - hw/rp_frontend_top.sv
  - target: test
    files:
      - test/tb_rp_frontend.sv

// ==== test/tb_rp_frontend.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_rp_frontend;

  import rp_frontend_pkg::*;

  logic adc_clk_01;
  logic rst_n_i;
  logic pll_locked_i;
  logic spi_done_i;
  logic [ADC_CH-1:0][ADC_PINS-1:0] adc_rise_i;
  logic [ADC_CH-1:0][ADC_PINS-1:0] adc_fall_i;
  logic [PDM_CH-1:0][PDM_DW-1:0]   pdm_cfg_i;
  logic [EXP_W-1:0] exp_p_in_i;
  logic [EXP_W-1:0] exp_n_in_i;
  logic [EXP_W-1:0] exp_p_out_i;
  logic [EXP_W-1:0] exp_n_out_i;
  logic [EXP_W-1:0] exp_p_dir_i;
  logic [EXP_W-1:0] exp_n_dir_i;
  logic can_on_i, trig_out_en_i, trig_out_sel_i;
  logic trig_scope_i, trig_asg_i, can0_tx_i, can1_tx_i;
  logic                          adc_rstn_o;
  adc_sample_t [ADC_CH-1:0]      adc_dat_o;
  logic [PDM_CH-1:0]             dac_pdm_o;
  logic [EXP_W-1:0]              exp_p_o;
  logic [EXP_W-1:0]              exp_n_o;
  logic [EXP_W-1:0]              exp_p_oe_o;
  logic [EXP_W-1:0]              exp_n_oe_o;
  logic                          trig_ext_o, can0_rx_o, can1_rx_o;

  logic [31:0] rng_state = 32'hdffc;
  int errors;
  int checks;
  int tests;
  int cyc;                                // posedge count
  logic adc_chk_en;                       // comparer takes codes
  logic [ADC_CH-1:0][ADC_DW-1:0] applied; // codes on the pins now
  logic [ADC_CH-1:0][ADC_DW-1:0] code_q[$];
  int tag_q[$];                           // capture edge per queued code

  rp_frontend_top DUT (.*);

  initial begin
    adc_clk_01 = 1'b0;
    forever #4 adc_clk_01 = ~adc_clk_01;
  end

  ////////////////////
  // reference
  ////////////////////

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  // sign bit stays, the 13 magnitude bits flip
  function automatic adc_sample_t exp_sample(logic [ADC_DW-1:0] code);
    return adc_sample_t'(code ^ {1'b0, {(ADC_DW-1){1'b1}}});
  endfunction

  // carries of a mod 256 accumulator over one full period
  function automatic int pdm_ones(logic [PDM_DW-1:0] setting);
    int acc = 0;
    int ones = 0;
    for (int i = 0; i < (1 << PDM_DW); i++) begin
      acc += setting;
      if (acc >= (1 << PDM_DW)) begin
        acc -= (1 << PDM_DW);
        ones++;
      end
    end
    return ones;
  endfunction

  // n side {oe, out} from the driven connector inputs
  function automatic logic [2*EXP_W-1:0] exp_n_side();
    logic [EXP_W-1:0] out;
    logic [EXP_W-1:0] oe;
    out = exp_n_out_i;
    oe  = exp_n_dir_i;
    if (trig_out_en_i) begin
      out[EXP_TRIG_PIN] = trig_out_sel_i ? trig_asg_i : trig_scope_i;
      oe[EXP_TRIG_PIN]  = 1'b1;
    end
    if (can_on_i) begin
      out[EXP_CAN0_PIN] = can0_tx_i;
      out[EXP_CAN1_PIN] = can1_tx_i;
      oe[EXP_CAN0_PIN]  = 1'b1;
      oe[EXP_CAN1_PIN]  = 1'b1;
    end
    return {oe, out};
  endfunction

  ////////////////////
  // checks
  ////////////////////

  task automatic check_sample(string name, adc_sample_t got, adc_sample_t want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("MISMATCH %0t %s got %0d want %0d", $time, name, got, want);
    end
  endtask

  task automatic check_count(string name, int got, int want);
    checks++;
    if (got != want) begin
      errors++;
      $display("MISMATCH %0t %s got %0d want %0d", $time, name, got, want);
    end
  endtask

  task automatic check_pins(string name, logic [EXP_W-1:0] got, logic [EXP_W-1:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("MISMATCH %0t %s got %h want %h", $time, name, got, want);
    end
  endtask

  task automatic end_test(string name, int err0);
    tests++;
    $display("test %s: %s", name, (errors == err0) ? "ok" : "FAILED");
  endtask

  task automatic wrap_up();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  task automatic timed_out(string what);
    errors++;
    $display("timeout at %0t waiting for %s", $time, what);
    wrap_up();
  endtask

  // fall bit is code bit 2k, rise bit 2k+1
  task automatic drive_codes(logic [ADC_CH-1:0][ADC_DW-1:0] codes);
    applied = codes;
    for (int ch = 0; ch < ADC_CH; ch++) begin
      for (int k = 0; k < ADC_PINS; k++) begin
        adc_fall_i[ch][k] = codes[ch][2*k];
        adc_rise_i[ch][k] = codes[ch][2*k+1];
      end
    end
  endtask

  // raise lock, count cycles to data path release, reset values meanwhile
  task automatic lock_hold();
    int n = 0;
    pll_locked_i = 1'b1;
    do begin
      @(negedge adc_clk_01);
      n++;
      if (!adc_rstn_o) begin
        for (int ch = 0; ch < ADC_CH; ch++) begin
          check_sample($sformatf("adc_dat_o[%0d]", ch), adc_dat_o[ch], '0);
        end
        check_count("dac_pdm_o", int'(dac_pdm_o), 0);
      end
      if (n > 4 * RST_MAX) timed_out("adc_rstn_o after pll lock");
    end while (!adc_rstn_o);
    check_count("adc_rstn_o rise cycle", n - 1, RST_MAX + 2);  // first edge sees lock
  endtask

  ////////////////////
  // adc comparer
  ////////////////////

  always @(posedge adc_clk_01) begin
    cyc = cyc + 1;
    if (adc_chk_en) begin
      code_q.push_back(applied);
      tag_q.push_back(cyc);
    end
  end

  // capture, convert, output: third edge after capture
  always @(negedge adc_clk_01) begin
    logic [ADC_CH-1:0][ADC_DW-1:0] code;
    if (tag_q.size() > 0 && cyc - tag_q[0] == 2) begin
      code = code_q.pop_front();
      void'(tag_q.pop_front());
      for (int ch = 0; ch < ADC_CH; ch++) begin
        check_sample($sformatf("adc_dat_o[%0d]", ch), adc_dat_o[ch], exp_sample(code[ch]));
      end
    end
  end

  ////////////////////
  // sequence
  ////////////////////

  initial begin
    int err0;
    int n;
    int ones[PDM_CH];
    logic [ADC_CH-1:0][ADC_DW-1:0] codes;
    logic [ADC_DW-1:0] corner[4];
    logic [PDM_DW-1:0] vals[6];
    logic [2*EXP_W-1:0] want;
    errors = 0;
    checks = 0;
    tests = 0;
    cyc = 0;
    adc_chk_en = 1'b0;
    rst_n_i = 1'b0;
    pll_locked_i = 1'b0;
    spi_done_i = 1'b1;  // adc setup already done
    drive_codes({14'h1234, 14'h0abc, 14'h3f00, 14'h00ff});
    pdm_cfg_i = {PDM_CH{8'h80}};
    exp_p_in_i = '0;
    exp_n_in_i = '0;
    exp_p_out_i = '0;
    exp_n_out_i = '0;
    exp_p_dir_i = '0;
    exp_n_dir_i = '0;
    {can_on_i, trig_out_en_i, trig_out_sel_i} = '0;
    {trig_scope_i, trig_asg_i, can0_tx_i, can1_tx_i} = '0;
    repeat (4) @(posedge adc_clk_01);
    @(negedge adc_clk_01);
    rst_n_i = 1'b1;
    repeat (4) @(negedge adc_clk_01);  // done flag through the sync

    err0 = errors;
    lock_hold();
    pll_locked_i = 1'b0;  // lose lock, hold again
    n = 0;
    do begin
      @(negedge adc_clk_01);
      n++;
      if (n > 8) timed_out("adc_rstn_o low after lock loss");
    end while (adc_rstn_o);
    lock_hold();
    end_test("reset_hold", err0);

    err0 = errors;
    corner = '{14'd0, 14'd8191, 14'd8192, 14'd16383};
    for (int i = 0; i < 200; i++) begin
      for (int ch = 0; ch < ADC_CH; ch++) begin
        codes[ch] = (i < 4) ? corner[(i + ch) % 4] : ADC_DW'(next_rand());
      end
      drive_codes(codes);
      adc_chk_en = 1'b1;
      @(negedge adc_clk_01);
    end
    adc_chk_en = 1'b0;
    n = 0;
    while (tag_q.size() != 0) begin  // pipeline drain
      @(negedge adc_clk_01);
      n++;
      if (n > 8) timed_out("adc compare queue to drain");
    end
    end_test("adc_conversion", err0);

    err0 = errors;
    vals = '{8'd0, 8'd1, 8'd128, 8'd255, PDM_DW'(next_rand()), PDM_DW'(next_rand())};
    for (int p = 0; p < 6; p++) begin
      for (int i = 0; i < PDM_CH; i++) begin
        pdm_cfg_i[i] = vals[(p + i) % 6];
        ones[i] = 0;
      end
      repeat (1 << PDM_DW) begin
        @(negedge adc_clk_01);
        for (int i = 0; i < PDM_CH; i++) ones[i] += dac_pdm_o[i];
      end
      for (int i = 0; i < PDM_CH; i++) begin
        check_count($sformatf("dac_pdm_o[%0d] ones", i), ones[i], pdm_ones(pdm_cfg_i[i]));
      end
    end
    end_test("pdm_density", err0);

    err0 = errors;
    for (int c = 0; c < 8; c++) begin
      {can_on_i, trig_out_en_i, trig_out_sel_i} = 3'(c);
      exp_p_out_i = EXP_W'(next_rand());
      exp_n_out_i = EXP_W'(next_rand());
      exp_p_dir_i = EXP_W'(next_rand());
      exp_n_dir_i = EXP_W'(next_rand());
      {trig_scope_i, trig_asg_i, can0_tx_i, can1_tx_i} = 4'(next_rand());
      @(posedge adc_clk_01);  // mux settled
      want = exp_n_side();
      check_pins("exp_n_o", exp_n_o, want[EXP_W-1:0]);
      check_pins("exp_n_oe_o", exp_n_oe_o, want[2*EXP_W-1:EXP_W]);
      check_pins("exp_p_o", exp_p_o, exp_p_out_i);
      check_pins("exp_p_oe_o", exp_p_oe_o, exp_p_dir_i);
      @(negedge adc_clk_01);
    end
    end_test("connector_mux", err0);

    err0 = errors;
    for (int on = 0; on < 2; on++) begin
      can_on_i = on[0];
      for (int s = 0; s < 8; s++) begin
        exp_p_in_i = EXP_W'(next_rand());
        exp_p_in_i[EXP_TRIG_PIN] = s[0];
        exp_p_in_i[EXP_CAN0_PIN] = s[1];
        exp_p_in_i[EXP_CAN1_PIN] = s[2];
        n = 0;
        do begin
          @(negedge adc_clk_01);
          n++;
          if (on == 0) begin
            check_count("can0_rx_o", int'(can0_rx_o), 0);
            check_count("can1_rx_o", int'(can1_rx_o), 0);
          end
          if (n > 8) timed_out("trig_ext_o to follow exp_p_in_i[0]");
        end while (trig_ext_o != s[0]);
        // rx lines share the trigger's sync stages
        check_count("can0_rx_o", int'(can0_rx_o), int'(on[0] & s[1]));
        check_count("can1_rx_o", int'(can1_rx_o), int'(on[0] & s[2]));
      end
    end
    end_test("connector_sync", err0);

    wrap_up();
  end

endmodule

`default_nettype wire

// ==== hw/rp_frontend_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module rp_frontend_top (
  input  logic adc_clk_01,    // adc clock, whole design
  input  logic rst_n_i,       // board reset
  input  logic pll_locked_i,
  input  logic spi_done_i,
  // adc pins after iddr
  input  logic [rp_frontend_pkg::ADC_CH-1:0][rp_frontend_pkg::ADC_PINS-1:0] adc_rise_i,
  input  logic [rp_frontend_pkg::ADC_CH-1:0][rp_frontend_pkg::ADC_PINS-1:0] adc_fall_i,
  // pdm settings
  input  logic [rp_frontend_pkg::PDM_CH-1:0][rp_frontend_pkg::PDM_DW-1:0]   pdm_cfg_i,
  // expansion connector
  input  logic [rp_frontend_pkg::EXP_W-1:0] exp_p_in_i,
  input  logic [rp_frontend_pkg::EXP_W-1:0] exp_n_in_i,
  input  logic [rp_frontend_pkg::EXP_W-1:0] exp_p_out_i,
  input  logic [rp_frontend_pkg::EXP_W-1:0] exp_n_out_i,
  input  logic [rp_frontend_pkg::EXP_W-1:0] exp_p_dir_i,
  input  logic [rp_frontend_pkg::EXP_W-1:0] exp_n_dir_i,
  input  logic                              can_on_i,
  input  logic                              trig_out_en_i,
  input  logic                              trig_out_sel_i,
  input  logic                              trig_scope_i,
  input  logic                              trig_asg_i,
  input  logic                              can0_tx_i,
  input  logic                              can1_tx_i,
  // outputs
  output logic                                                   adc_rstn_o,
  output rp_frontend_pkg::adc_sample_t [rp_frontend_pkg::ADC_CH-1:0] adc_dat_o,
  output logic [rp_frontend_pkg::PDM_CH-1:0]                     dac_pdm_o,
  output logic [rp_frontend_pkg::EXP_W-1:0]                      exp_p_o,
  output logic [rp_frontend_pkg::EXP_W-1:0]                      exp_n_o,
  output logic [rp_frontend_pkg::EXP_W-1:0]                      exp_p_oe_o,
  output logic [rp_frontend_pkg::EXP_W-1:0]                      exp_n_oe_o,
  output logic                                                   trig_ext_o,
  output logic                                                   can0_rx_o,
  output logic                                                   can1_rx_o
);

  import rp_frontend_pkg::*;

  logic adc_rstn;  // data path reset for every block below

  ////////////////////
  // reset sequencing
  ////////////////////

  rp_reset_seq i_reset_seq (
    .adc_clk_01   (adc_clk_01  ),
    .rst_n_i      (rst_n_i     ),
    .pll_locked_i (pll_locked_i),
    .spi_done_i   (spi_done_i  ),
    .adc_rstn_o   (adc_rstn    )
  );

  assign adc_rstn_o = adc_rstn;

  // all four channels on adc_clk_01
  for (genvar ch = 0; ch < ADC_CH; ch++) begin : g_adc
    rp_adc_fmt i_adc_fmt (
      .adc_clk_01 (adc_clk_01    ),
      .rst_n_i    (adc_rstn      ),
      .dat_rise_i (adc_rise_i[ch]),
      .dat_fall_i (adc_fall_i[ch]),
      .dat_o      (adc_dat_o[ch] )
    );
  end

  rp_pdm i_pdm (
    .adc_clk_01 (adc_clk_01),
    .rst_n_i    (adc_rstn  ),
    .cfg_i      (pdm_cfg_i ),
    .pdm_o      (dac_pdm_o )
  );

  rp_exp_pins i_exp_pins (
    .adc_clk_01     (adc_clk_01    ),
    .rst_n_i        (adc_rstn      ),
    .exp_p_in_i     (exp_p_in_i    ),
    .exp_n_in_i     (exp_n_in_i    ),
    .exp_p_out_i    (exp_p_out_i   ),
    .exp_n_out_i    (exp_n_out_i   ),
    .exp_p_dir_i    (exp_p_dir_i   ),
    .exp_n_dir_i    (exp_n_dir_i   ),
    .can_on_i       (can_on_i      ),
    .trig_out_en_i  (trig_out_en_i ),
    .trig_out_sel_i (trig_out_sel_i),
    .trig_scope_i   (trig_scope_i  ),
    .trig_asg_i     (trig_asg_i    ),
    .can0_tx_i      (can0_tx_i     ),
    .can1_tx_i      (can1_tx_i     ),
    .exp_p_o        (exp_p_o       ),
    .exp_n_o        (exp_n_o       ),
    .exp_p_oe_o     (exp_p_oe_o    ),
    .exp_n_oe_o     (exp_n_oe_o    ),
    .trig_ext_o     (trig_ext_o    ),
    .can0_rx_o      (can0_rx_o     ),
    .can1_rx_o      (can1_rx_o     )
  );

endmodule

`default_nettype wire

// ==== hw/rp_exp_pins.sv ====
`timescale 1ns/1ns
`default_nettype none

module rp_exp_pins (
  input  logic                              adc_clk_01,      // adc clock
  input  logic                              rst_n_i,         // data path reset
  // pad side
  input  logic [rp_frontend_pkg::EXP_W-1:0] exp_p_in_i,      // p pad inputs
  input  logic [rp_frontend_pkg::EXP_W-1:0] exp_n_in_i,      // n pad inputs, no alt use
  // gpio settings
  input  logic [rp_frontend_pkg::EXP_W-1:0] exp_p_out_i,
  input  logic [rp_frontend_pkg::EXP_W-1:0] exp_n_out_i,
  input  logic [rp_frontend_pkg::EXP_W-1:0] exp_p_dir_i,     // 1 = output
  input  logic [rp_frontend_pkg::EXP_W-1:0] exp_n_dir_i,
  // alternate functions
  input  logic                              can_on_i,        // can owns pins 7 and 6
  input  logic                              trig_out_en_i,   // trigger owns n pin 0
  input  logic                              trig_out_sel_i,  // 1 = asg, 0 = scope
  input  logic                              trig_scope_i,
  input  logic                              trig_asg_i,
  input  logic                              can0_tx_i,
  input  logic                              can1_tx_i,
  // to pads
  output logic [rp_frontend_pkg::EXP_W-1:0] exp_p_o,
  output logic [rp_frontend_pkg::EXP_W-1:0] exp_n_o,
  output logic [rp_frontend_pkg::EXP_W-1:0] exp_p_oe_o,
  output logic [rp_frontend_pkg::EXP_W-1:0] exp_n_oe_o,
  // synchronized inputs
  output logic                              trig_ext_o,
  output logic                              can0_rx_o,
  output logic                              can1_rx_o
);

  import rp_frontend_pkg::*;

  logic [EXP_W-1:0]             n_alt;      // n pins taken by an alt function
  logic [EXP_W-1:0]             n_alt_dat;  // alt drive values
  logic                         trig_out;
  logic [2:0]                   sync_d;     // {can1 rx, can0 rx, trig}
  logic [SYNC_STAGES-1:0][2:0]  sync_q;

  ////////////////////
  // output mux
  ////////////////////

  assign trig_out = trig_out_sel_i ? trig_asg_i : trig_scope_i;

  always_comb begin
    n_alt     = '0;
    n_alt_dat = '0;
    n_alt[EXP_TRIG_PIN]     = trig_out_en_i;
    n_alt_dat[EXP_TRIG_PIN] = trig_out;
    n_alt[EXP_CAN0_PIN]     = can_on_i;
    n_alt_dat[EXP_CAN0_PIN] = can0_tx_i;
    n_alt[EXP_CAN1_PIN]     = can_on_i;
    n_alt_dat[EXP_CAN1_PIN] = can1_tx_i;
  end

  assign exp_p_o    = exp_p_out_i;  // no alt on p side
  assign exp_p_oe_o = exp_p_dir_i;
  assign exp_n_o    = (n_alt & n_alt_dat) | (~n_alt & exp_n_out_i);
  assign exp_n_oe_o = n_alt | exp_n_dir_i;  // alt pins always drive

  ////////////////////
  // input sync
  ////////////////////

  // can rx gated before the sync, so it reads low with can off
  assign sync_d = {can_on_i & exp_p_in_i[EXP_CAN1_PIN],
                   can_on_i & exp_p_in_i[EXP_CAN0_PIN],
                   exp_p_in_i[EXP_TRIG_PIN]};

  always_ff @(posedge adc_clk_01 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[SYNC_STAGES-2:0], sync_d};
    end
  end

  assign trig_ext_o = sync_q[SYNC_STAGES-1][0];
  assign can0_rx_o  = sync_q[SYNC_STAGES-1][1];
  assign can1_rx_o  = sync_q[SYNC_STAGES-1][2];

  // alt function enables force the pad driver on
  a_alt_oe: assert property (@(posedge adc_clk_01) disable iff (!rst_n_i)
    (!trig_out_en_i || exp_n_oe_o[EXP_TRIG_PIN]) &&
    (!can_on_i || (exp_n_oe_o[EXP_CAN0_PIN] && exp_n_oe_o[EXP_CAN1_PIN])));

endmodule

`default_nettype wire

// ==== hw/rp_pdm.sv ====
`timescale 1ns/1ns
`default_nettype none

module rp_pdm (
  input  logic adc_clk_01,  // adc clock
  input  logic rst_n_i,     // data path reset
  // per channel density, ones per 256 cycles
  input  logic [rp_frontend_pkg::PDM_CH-1:0][rp_frontend_pkg::PDM_DW-1:0] cfg_i,
  output logic [rp_frontend_pkg::PDM_CH-1:0]                              pdm_o
);

  import rp_frontend_pkg::*;

  logic [PDM_CH-1:0][PDM_DW-1:0] acc;  // sigma-delta accumulators
  logic [PDM_CH-1:0][PDM_DW:0]   sum;  // acc + setting, carry on top

  ////////////////////
  // first order loop
  ////////////////////

  always_comb begin
    for (int i = 0; i < PDM_CH; i++) begin
      sum[i] = {1'b0, acc[i]} + {1'b0, cfg_i[i]};
    end
  end

  // wraps at 256, the carry is the pulse
  always_ff @(posedge adc_clk_01 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      acc   <= '0;
      pdm_o <= '0;
    end else begin
      for (int i = 0; i < PDM_CH; i++) begin
        acc[i]   <= sum[i][PDM_DW-1:0];
        pdm_o[i] <= sum[i][PDM_DW];  // registered carry
      end
    end
  end

  // zero setting can never produce a carry
  for (genvar gi = 0; gi < PDM_CH; gi++) begin : g_chk
    a_zero_quiet: assert property (@(posedge adc_clk_01) disable iff (!rst_n_i)
      (cfg_i[gi] == '0) |=> !pdm_o[gi]);
  end

endmodule

`default_nettype wire

// ==== hw/rp_adc_fmt.sv ====
`timescale 1ns/1ns
`default_nettype none

module rp_adc_fmt (
  input  logic                                 adc_clk_01,  // adc clock
  input  logic                                 rst_n_i,     // data path reset
  input  logic [rp_frontend_pkg::ADC_PINS-1:0] dat_rise_i,  // iddr rising edge bits
  input  logic [rp_frontend_pkg::ADC_PINS-1:0] dat_fall_i,  // iddr falling edge bits
  output rp_frontend_pkg::adc_sample_t         dat_o        // two's complement sample
);

  import rp_frontend_pkg::*;

  adc_raw_t    raw_d;   // assembled word
  adc_raw_t    raw_q;   // capture stage
  adc_sample_t conv_q;  // convert stage

  ////////////////////
  // ddr assembly
  ////////////////////

  // fall bit is the even code bit, rise bit the odd one
  always_comb begin
    for (int k = 0; k < ADC_PINS; k++) begin
      raw_d.pins[k] = {dat_rise_i[k], dat_fall_i[k]};
    end
  end

  // register to register point right after the pins
  always_ff @(posedge adc_clk_01) begin
    raw_q <= raw_d;
  end

  ////////////////////
  // code conversion
  ////////////////////

  // negative slope offset code to two's complement
  // msb kept, magnitude bits flipped
  always_ff @(posedge adc_clk_01) begin
    conv_q <= {raw_q.code[ADC_DW-1], ~raw_q.code[ADC_DW-2:0]};
  end

  // output stage, zero while held in reset
  always_ff @(posedge adc_clk_01 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dat_o <= '0;
    end else begin
      dat_o <= conv_q;
    end
  end

  // pipeline filled from the pins by the time reset lifts
  a_no_x: assert property (@(posedge adc_clk_01) disable iff (!rst_n_i)
    !$isunknown(dat_o));

endmodule

`default_nettype wire

// ==== hw/rp_reset_seq.sv ====
`timescale 1ns/1ns
`default_nettype none

module rp_reset_seq (
  input  logic adc_clk_01,    // adc clock
  input  logic rst_n_i,       // board reset
  input  logic pll_locked_i,  // pll lock status
  input  logic spi_done_i,    // adc setup over spi finished
  output logic adc_rstn_o     // data path reset, active low
);

  import rp_frontend_pkg::*;

  logic [SYNC_STAGES-1:0] done_sync;  // setup done synchronizer chain
  logic                   done_adc;   // setup done in adc domain
  logic                   lock_q;     // lock delayed one cycle
  logic                   lock_edge;  // registered rising edge of lock
  logic [RST_CNT_W-1:0]   hold_cnt;   // cycles since lock edge
  logic                   hold;

  ////////////////////
  // setup done sync
  ////////////////////

  always_ff @(posedge adc_clk_01 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      done_sync <= '0;
    end else begin
      done_sync <= {done_sync[SYNC_STAGES-2:0], spi_done_i};  // shift in at bit 0
    end
  end

  assign done_adc = done_sync[SYNC_STAGES-1];

  ////////////////////
  // lock hold window
  ////////////////////

  always_ff @(posedge adc_clk_01 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_q    <= 1'b0;
      lock_edge <= 1'b0;
    end else begin
      lock_q    <= pll_locked_i;
      lock_edge <= pll_locked_i & ~lock_q;  // one pulse per lock
    end
  end

  // counter starts the cycle after the edge pulse, runs 1..RST_MAX
  always_ff @(posedge adc_clk_01 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hold_cnt <= '0;
    end else if (!pll_locked_i) begin
      hold_cnt <= '0;  // lost lock, start over on next edge
    end else if (lock_edge || (hold_cnt != '0)) begin
      if (hold_cnt < RST_MAX) begin
        hold_cnt <= hold_cnt + 1'b1;
      end else begin
        hold_cnt <= '0;  // window over
      end
    end
  end

  // edge pulse covers the cycle before the counter goes nonzero
  assign hold = lock_edge | (hold_cnt != '0);

  always_ff @(posedge adc_clk_01 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      adc_rstn_o <= 1'b0;
    end else begin
      adc_rstn_o <= done_adc & ~hold & lock_q & pll_locked_i;  // lock_q masks edge cycle
    end
  end

  // counter never leaves the window
  a_hold_max: assert property (@(posedge adc_clk_01) disable iff (!rst_n_i)
    hold_cnt <= RST_MAX);

  // a fresh lock keeps the data path in reset for the full hold
  a_hold_len: assert property (@(posedge adc_clk_01) disable iff (!rst_n_i)
    lock_edge |=> !adc_rstn_o [*(RST_MAX + 1)]);

endmodule

`default_nettype wire

// ==== hw/rp_frontend_pkg.sv ====
`default_nettype none

package rp_frontend_pkg;

  ////////////////////
  // adc
  ////////////////////

  localparam int unsigned ADC_CH   = 4;           // channels on the board
  localparam int unsigned ADC_DW   = 14;          // sample width
  localparam int unsigned ADC_PINS = ADC_DW / 2;  // ddr pins per channel, 2 bits each

  ////////////////////
  // pdm
  ////////////////////

  localparam int unsigned PDM_CH = 4;  // slow analog outputs
  localparam int unsigned PDM_DW = 8;  // setting width, full range 256

  ////////////////////
  // expansion
  ////////////////////

  localparam int unsigned EXP_W        = 11;  // pins per side
  localparam int unsigned EXP_TRIG_PIN = 0;   // n out: trigger, p in: ext trigger
  localparam int unsigned EXP_CAN0_PIN = 7;   // n: can0 tx, p: can0 rx
  localparam int unsigned EXP_CAN1_PIN = 6;   // n: can1 tx, p: can1 rx

  ////////////////////
  // reset and sync
  ////////////////////

  localparam int unsigned RST_MAX     = 64;                   // hold after pll lock
  localparam int unsigned RST_CNT_W   = $clog2(RST_MAX + 1);  // hold counter width
  localparam int unsigned SYNC_STAGES = 2;                    // flops per synchronizer

  // raw adc word as it comes off the ddr pins
  // pins[k] = {rise, fall} of pin k, so pin k holds code bits 2k+1 and 2k
  typedef union packed {
    logic [ADC_DW-1:0]        code;  // plain offset code, negative slope
    logic [ADC_PINS-1:0][1:0] pins;  // per pin ddr pair
  } adc_raw_t;

  // converted sample, two's complement
  typedef logic signed [ADC_DW-1:0] adc_sample_t;

endpackage

`default_nettype wire
